//--- vlog.f
hw/rp_pkg.sv
hw/lin_scale.sv
hw/adc_front.sv
hw/dac_back.sv
hw/trig_debounce.sv
hw/rp_top.sv
test/rp_properties.sv
test/tb_checker.sv
test/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -Mdir obj_dir --top-module tb_top -f vlog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the run counts as passed only if the testbench said so
if echo "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1

//--- test/tb_top.sv
`timescale 1ns/1ns

module tb_top import rp_pkg::*; ();

  localparam int CH_N    = 2;
  localparam int DEB_LEN = 8;
  // test lengths in cycles
  localparam int ADC_LEN    = 200;
  localparam int CAL_LEN    = 400;
  localparam int DAC_LEN    = 300;
  localparam int LOOP_LEN   = 300;
  localparam int HOLD_LEN   = 3 * DEB_LEN;
  localparam int GLITCH_LEN = DEB_LEN / 2;
  localparam int TRIG_LEN   = 6 * HOLD_LEN + 2 * GLITCH_LEN;
  // reset, 4 flush cycles per test, margin
  localparam int RUN_LIMIT  = 3 + ADC_LEN + CAL_LEN + DAC_LEN + LOOP_LEN + TRIG_LEN + 5 * 4 + 100;

  localparam cal_t UNITY = '{mul: mul_t'(1 << MUL_FRAC), sum: sum_t'(0)};

  logic                adc_clk;
  logic                top_rst;
  raw_t     [CH_N-1:0] adc_dat;
  logic     [CH_N-1:0] loop;
  cal_t     [CH_N-1:0] adc_cal;
  cal_t     [CH_N-1:0] dac_cal;
  smp_str_t [CH_N-1:0] gen;
  logic     [CH_N-1:0] gen_rdy;
  smp_str_t [CH_N-1:0] adc_str;
  raw_t     [CH_N-1:0] dac_dat;
  logic                exp_in;
  logic                trg_pos;
  logic                trg_neg;
  logic [31:0]         seed = 32'h4b9f;
  int                  cyc  = 0;

  rp_top #(
    .CH_N    (CH_N),
    .DEB_LEN (DEB_LEN),
    .DEB_W   (20)
  ) UUT (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat),
    .loop_i    (loop),
    .adc_cal_i (adc_cal),
    .dac_cal_i (dac_cal),
    .gen_i     (gen),
    .gen_rdy_o (gen_rdy),
    .adc_o     (adc_str),
    .dac_dat_o (dac_dat),
    .exp_i     (exp_in),
    .trg_pos_o (trg_pos),
    .trg_neg_o (trg_neg)
  );

  tb_checker #(
    .CH_N (CH_N)
  ) chk (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat),
    .loop_i    (loop),
    .adc_cal_i (adc_cal),
    .dac_cal_i (dac_cal),
    .gen_i     (gen),
    .gen_rdy_i (gen_rdy),
    .adc_str_i (adc_str),
    .dac_dat_i (dac_dat),
    .exp_i     (exp_in),
    .trg_pos_i (trg_pos),
    .trg_neg_i (trg_neg)
  );

  bind rp_top rp_properties #(
    .CH_N (CH_N)
  ) u_props (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .loop_i    (loop_i),
    .gen_i     (gen_i),
    .gen_rdy_i (gen_rdy_o),
    .adc_str_i (adc_o),
    .dac_dat_i (dac_dat_o),
    .trg_pos_i (trg_pos_o),
    .trg_neg_i (trg_neg_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // clock, random source, drive helpers
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // low LCG bits repeat quickly so only the upper half is used
  function automatic logic [15:0] rnd16();
    seed = lcg_step(seed);
    return seed[31:16];
  endfunction

  // gains near both ends of the range and offsets at the limits
  function automatic cal_t pick_cal();
    cal_t        c;
    logic [15:0] r;
    r     = rnd16();
    c.mul = mul_t'(rnd16());
    c.sum = sum_t'(rnd16());
    case (r[15:14])
      2'd0:    c.mul = mul_t'(16'h7fff);
      2'd1:    c.mul = mul_t'(16'h8000);
      2'd2:    c.sum = r[13] ? sum_t'(14'h1fff) : sum_t'(14'h2000);
      default: c.mul = mul_t'(rnd16());
    endcase
    return c;
  endfunction

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge adc_clk);
    #1;
  endtask

  task automatic drive_pins();
    for (int ch = 0; ch < CH_N; ch++) begin
      adc_dat[ch] = raw_t'(rnd16());
    end
  endtask

  // new item only once the old one has gone
  task automatic drive_gen();
    for (int ch = 0; ch < CH_N; ch++) begin
      if (!(gen[ch].vld && !gen_rdy[ch])) begin
        gen[ch].vld = rnd16() < 16'd40000;
        gen[ch].dat = smp_t'(rnd16());
      end
    end
  endtask

  task automatic hold_exp(input logic v, input int n);
    exp_in = v;
    repeat (n) next_cycle();
  endtask

  task automatic close_test(input string name);
    repeat (4) next_cycle();
    chk.end_test(name);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    top_rst = 1'b1;
    adc_dat = '0;
    loop    = '0;
    adc_cal = {CH_N{UNITY}};
    dac_cal = {CH_N{UNITY}};
    gen     = '0;
    exp_in  = 1'b0;
    repeat (3) @(posedge adc_clk);
    #1;
    top_rst = 1'b0;

    // pins straight through
    repeat (ADC_LEN) begin
      drive_pins();
      next_cycle();
    end
    close_test("adc path");

    // new calibration every 16 cycles
    for (int i = 0; i < CAL_LEN; i++) begin
      if (i % 16 == 0) begin
        adc_cal[0] = pick_cal();
        adc_cal[1] = pick_cal();
      end
      drive_pins();
      next_cycle();
    end
    chk.check_clamp();
    close_test("calibration and saturation");
    adc_cal = {CH_N{UNITY}};

    // generator stream with gaps
    dac_cal[0] = pick_cal();
    dac_cal[1] = pick_cal();
    repeat (DAC_LEN) begin
      drive_gen();
      drive_pins();
      next_cycle();
    end
    gen = '0;
    close_test("dac path");

    // channel 0 loops back, channel 1 stays on its pins
    loop       = 2'b01;
    adc_cal[0] = pick_cal();
    repeat (LOOP_LEN) begin
      drive_gen();
      drive_pins();
      next_cycle();
    end
    gen  = '0;
    loop = '0;
    close_test("loopback");

    // two clean pulses each way with short glitches in between
    hold_exp(1'b1, HOLD_LEN);
    hold_exp(1'b0, GLITCH_LEN);
    hold_exp(1'b1, HOLD_LEN);
    hold_exp(1'b0, HOLD_LEN);
    hold_exp(1'b1, GLITCH_LEN);
    hold_exp(1'b0, HOLD_LEN);
    hold_exp(1'b1, HOLD_LEN);
    hold_exp(1'b0, HOLD_LEN);
    chk.check_trig(2, 2);
    close_test("trigger");

    chk.report();
    if (chk.err_cnt == 0 && UUT.u_props.ast_err == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // run limit from the summed test lengths
  always @(posedge adc_clk) begin
    cyc = cyc + 1;
    if (cyc >= RUN_LIMIT) begin
      $display("ERROR t=%0t run did not finish within %0d cycles", $time, RUN_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

endmodule : tb_top

//--- test/tb_checker.sv
`timescale 1ns/1ns

module tb_checker import rp_pkg::*; #(
  parameter int CH_N = 2
) (
  input logic                adc_clk,
  input logic                top_rst,
  input raw_t     [CH_N-1:0] adc_dat_i,
  input logic     [CH_N-1:0] loop_i,
  input cal_t     [CH_N-1:0] adc_cal_i,
  input cal_t     [CH_N-1:0] dac_cal_i,
  input smp_str_t [CH_N-1:0] gen_i,
  input logic     [CH_N-1:0] gen_rdy_i,
  input smp_str_t [CH_N-1:0] adc_str_i,
  input raw_t     [CH_N-1:0] dac_dat_i,
  input logic                exp_i,
  input logic                trg_pos_i,
  input logic                trg_neg_i
);

  // signed sample range
  localparam longint SMAX = 2**(SMP_W-1) - 1;
  localparam longint SMIN = -(2**(SMP_W-1));

  int err_cnt  = 0;
  int test_cnt = 0;
  int fail_cnt = 0;
  int err_mark = 0;
  int pos_cnt  = 0;
  int neg_cnt  = 0;
  bit clamp_hi = 1'b0;
  bit clamp_lo = 1'b0;

  // expected adc_o samples per channel
  smp_t adc_exp_q [CH_N][$];
  // model of the sample register and the DAC calibration output
  logic [CH_N-1:0] reg_vld;
  smp_t            reg_dat [CH_N];
  logic [CH_N-1:0] lin_vld;
  smp_t            lin_dat [CH_N];
  raw_t            code_exp [CH_N];
  smp_t            exp_s;

  ////////////////////////////////////////////////////////////////////////////
  // reference functions
  ////////////////////////////////////////////////////////////////////////////

  // top bit kept, the rest flipped
  function automatic smp_t fmt_pin(input raw_t w);
    return smp_t'(w ^ raw_t'(2**(SMP_W-1) - 1));
  endfunction

  // gain with 13 fraction bits, offset, clamp to sample range
  function automatic smp_t scale_sat(input smp_t s, input cal_t c);
    longint acc;
    acc = (longint'(s) * longint'($signed(c.mul))) >>> MUL_FRAC;
    acc = acc + longint'($signed(c.sum));
    if (acc > SMAX) begin
      acc = SMAX;
    end else if (acc < SMIN) begin
      acc = SMIN;
    end
    return smp_t'(acc);
  endfunction

  function automatic raw_t dac_code(input smp_t s);
    return raw_t'(s) ^ raw_t'(2**(SMP_W-1) - 1);
  endfunction

  task automatic value_error(input string name, input int ch,
                             input logic [SMP_W-1:0] exp_v, input logic [SMP_W-1:0] act_v);
    $display("ERROR t=%0t %s[%0d] expected %h got %h", $time, name, ch, exp_v, act_v);
    err_cnt++;
  endtask

  task automatic fail_note(input string what);
    $display("ERROR t=%0t %s", $time, what);
    err_cnt++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare ADC stream and DAC codes every cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk) begin
    if (top_rst) begin
      for (int ch = 0; ch < CH_N; ch++) begin
        adc_exp_q[ch].delete();
        lin_dat[ch]  = '0;
        code_exp[ch] = dac_code('0);
      end
      reg_vld = '0;
      lin_vld = '0;
    end else begin
      for (int ch = 0; ch < CH_N; ch++) begin
        // oldest expected sample against adc_o
        if (adc_str_i[ch].vld) begin
          if (adc_exp_q[ch].size() == 0) begin
            fail_note($sformatf("adc_o[%0d] valid with no sample expected", ch));
          end else begin
            exp_s = adc_exp_q[ch].pop_front();
            if (adc_str_i[ch].dat !== exp_s) begin
              value_error("adc_o.dat", ch, exp_s, adc_str_i[ch].dat);
            end
            clamp_hi = clamp_hi | (exp_s == smp_t'(SMAX));
            clamp_lo = clamp_lo | (exp_s == smp_t'(SMIN));
          end
        end
        // code must hold until the next calibrated sample
        if (dac_dat_i[ch] !== code_exp[ch]) begin
          value_error("dac_dat_o", ch, code_exp[ch], dac_dat_i[ch]);
        end
        if (lin_vld[ch]) begin
          code_exp[ch] = dac_code(lin_dat[ch]);
        end
        // ADC calibration takes the registered sample
        if (reg_vld[ch]) begin
          adc_exp_q[ch].push_back(scale_sat(reg_dat[ch], adc_cal_i[ch]));
        end
        if (adc_exp_q[ch].size() > 1) begin
          fail_note($sformatf("adc_o[%0d] missed an expected sample", ch));
          void'(adc_exp_q[ch].pop_front());
        end
        // sample register, pins or loopback
        if (loop_i[ch]) begin
          reg_vld[ch] = lin_vld[ch];
          reg_dat[ch] = lin_dat[ch];
        end else begin
          reg_vld[ch] = 1'b1;
          reg_dat[ch] = fmt_pin(adc_dat_i[ch]);
        end
        // DAC calibration on every transfer
        lin_vld[ch] = gen_i[ch].vld & gen_rdy_i[ch];
        if (lin_vld[ch]) begin
          lin_dat[ch] = scale_sat(gen_i[ch].dat, dac_cal_i[ch]);
        end
      end
    end
  end

  // trigger pulses, polarity against the settled input
  always @(posedge adc_clk) begin
    if (!top_rst && trg_pos_i) begin
      pos_cnt++;
      if (!exp_i) begin
        fail_note("rising trigger while exp_i is low");
      end
    end
    if (!top_rst && trg_neg_i) begin
      neg_cnt++;
      if (exp_i) begin
        fail_note("falling trigger while exp_i is high");
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // per test scoring
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_clamp();
    if (!clamp_hi) begin
      fail_note("no adc_o sample clamped at the positive limit");
    end
    if (!clamp_lo) begin
      fail_note("no adc_o sample clamped at the negative limit");
    end
  endtask

  task automatic check_trig(input int exp_pos, input int exp_neg);
    if (pos_cnt != exp_pos) begin
      fail_note($sformatf("trg_pos_o pulses expected %0d got %0d", exp_pos, pos_cnt));
    end
    if (neg_cnt != exp_neg) begin
      fail_note($sformatf("trg_neg_o pulses expected %0d got %0d", exp_neg, neg_cnt));
    end
  endtask

  task automatic end_test(input string name);
    int n_err;
    n_err = err_cnt - err_mark;
    test_cnt++;
    if (n_err == 0) begin
      $display("test %0d %s: passed", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: failed with %0d errors", test_cnt, name, n_err);
    end
    err_mark = err_cnt;
    clamp_hi = 1'b0;
    clamp_lo = 1'b0;
  endtask

  task automatic report();
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             test_cnt, test_cnt - fail_cnt, fail_cnt, err_cnt);
  endtask

endmodule : tb_checker

//--- test/rp_properties.sv
`timescale 1ns/1ns

module rp_properties import rp_pkg::*; #(
  parameter int CH_N = 2
) (
  input logic                adc_clk,
  input logic                top_rst,
  input logic     [CH_N-1:0] loop_i,
  input smp_str_t [CH_N-1:0] gen_i,
  input logic     [CH_N-1:0] gen_rdy_i,
  input smp_str_t [CH_N-1:0] adc_str_i,
  input raw_t     [CH_N-1:0] dac_dat_i,
  input logic                trg_pos_i,
  input logic                trg_neg_i
);

  // failed assertions so far
  int ast_err = 0;

  // DAC side takes every generator sample once running
  a_gen_rdy : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !$past(top_rst) |-> (&gen_rdy_i)
  ) else begin
    $error("gen_rdy_o low outside reset");
    ast_err++;
  end

  // one polarity per accepted edge
  a_trg_excl : assert property (
    @(posedge adc_clk) !(trg_pos_i && trg_neg_i)
  ) else begin
    $error("trg_pos_o and trg_neg_o high together");
    ast_err++;
  end

  for (genvar i = 0; i < CH_N; i++) begin : g_ch
    // pin path keeps the stream valid, loopback follows DAC valid
    a_adc_vld : assert property (
      @(posedge adc_clk) disable iff (top_rst)
      (!$past(top_rst, 1) && !$past(top_rst, 2) && !$past(loop_i[i], 2))
        |-> adc_str_i[i].vld
    ) else begin
      $error("adc_o valid dropped on a pin channel");
      ast_err++;
    end

    // code register moves only two cycles after a transfer
    a_dac_hold : assert property (
      @(posedge adc_clk) disable iff (top_rst)
      !$past(gen_i[i].vld && gen_rdy_i[i], 2) |-> $stable(dac_dat_i[i])
    ) else begin
      $error("dac_dat_o changed without a generator transfer");
      ast_err++;
    end
  end : g_ch

endmodule : rp_properties

//--- hw/rp_top.sv
`timescale 1ns/1ns

module rp_top import rp_pkg::*; #(
  parameter int          CH_N    = 2,
  parameter int unsigned DEB_LEN = 62500,
  parameter int unsigned DEB_W   = 20
) (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // ADC pins and loopback select
  input  raw_t     [CH_N-1:0]   adc_dat_i,
  input  logic     [CH_N-1:0]   loop_i,
  // calibration
  input  cal_t     [CH_N-1:0]   adc_cal_i,
  input  cal_t     [CH_N-1:0]   dac_cal_i,
  // generator stream
  input  smp_str_t [CH_N-1:0]   gen_i,
  output logic     [CH_N-1:0]   gen_rdy_o,
  // acquisition stream
  output smp_str_t [CH_N-1:0]   adc_o,
  // DAC codes
  output raw_t     [CH_N-1:0]   dac_dat_o,
  // GPIO trigger
  input  logic                  exp_i,
  output logic                  trg_pos_o,
  output logic                  trg_neg_o
);

  // calibrated DAC stream back into the ADC path
  smp_str_t [CH_N-1:0] dac_lin;

  ////////////////////////////////////////////////////////////////////////////
  // ADC and DAC channels
  ////////////////////////////////////////////////////////////////////////////

  adc_front #(
    .CH_N (CH_N)
  ) u_adc (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .loop_i    (loop_i),
    .adc_cal_i (adc_cal_i),
    .dac_lin_i (dac_lin),
    .adc_o     (adc_o)
  );

  dac_back #(
    .CH_N (CH_N)
  ) u_dac (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .gen_i     (gen_i),
    .gen_rdy_o (gen_rdy_o),
    .dac_cal_i (dac_cal_i),
    .dac_lin_o (dac_lin),
    .dac_dat_o (dac_dat_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // GPIO trigger
  ////////////////////////////////////////////////////////////////////////////

  trig_debounce #(
    .DEB_LEN (DEB_LEN),
    .DEB_W   (DEB_W)
  ) u_deb (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (exp_i),
    .pos_o   (trg_pos_o),
    .neg_o   (trg_neg_o)
  );

endmodule : rp_top

//--- hw/trig_debounce.sv
`timescale 1ns/1ns

module trig_debounce #(
  parameter int unsigned DEB_LEN = 62500,
  parameter int unsigned DEB_W   = 20
) (
  input  logic adc_clk,
  input  logic top_rst,
  // asynchronous GPIO bit
  input  logic dat_i,
  // one cycle edge pulses
  output logic pos_o,
  output logic neg_o
);

  logic [1:0]       sync_q;
  logic             deb_q;
  logic [DEB_W-1:0] cnt_q;
  logic             chg;
  logic             done;

  // synchronized input differs from accepted state
  assign chg  = sync_q[1] ^ deb_q;
  // change has stayed long enough
  assign done = chg && (cnt_q == DEB_W'(DEB_LEN - 1));

  ////////////////////////////////////////////////////////////////////////////
  // synchronizer, stability counter, edge pulses
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sync_q <= '0;
      deb_q  <= 1'b0;
      cnt_q  <= '0;
      pos_o  <= 1'b0;
      neg_o  <= 1'b0;
    end else begin
      // two flop synchronizer
      sync_q <= {sync_q[0], dat_i};
      // restart counting on every return to the accepted state
      if (!chg || done) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
      // accept the new state
      if (done) begin
        deb_q <= sync_q[1];
      end
      // pulse polarity from the new state
      pos_o <= done &  sync_q[1];
      neg_o <= done & ~sync_q[1];
    end
  end

endmodule : trig_debounce

//--- hw/dac_back.sv
`timescale 1ns/1ns

module dac_back import rp_pkg::*; #(
  parameter int CH_N = 2
) (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // generator stream and its ready
  input  smp_str_t [CH_N-1:0]   gen_i,
  output logic     [CH_N-1:0]   gen_rdy_o,
  input  cal_t     [CH_N-1:0]   dac_cal_i,
  // calibrated stream, also fed back for loopback
  output smp_str_t [CH_N-1:0]   dac_lin_o,
  // DAC codes
  output raw_t     [CH_N-1:0]   dac_dat_o
);

  // accept generator data from the first cycle after reset
  logic run_q;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  for (genvar i = 0; i < CH_N; i++) begin : g_ch

    logic lin_rdy;
    logic lin_vld;
    smp_t lin_dat;

    // DAC calibration
    lin_scale #(
      .DT (smp_t)
    ) u_lin (
      .clk_i     (adc_clk),
      .rst_i     (top_rst),
      .cal_i     (dac_cal_i[i]),
      .in_vld_i  (gen_i[i].vld & run_q),
      .in_dat_i  (gen_i[i].dat),
      .in_rdy_o  (lin_rdy),
      .out_vld_o (lin_vld),
      .out_dat_o (lin_dat),
      .out_rdy_i (1'b1)
    );

    assign gen_rdy_o[i] = run_q & lin_rdy;
    assign dac_lin_o[i] = '{vld: lin_vld, dat: lin_dat};

    // code register, reset value is the code of sample zero
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        dac_dat_o[i] <= {1'b0, {(SMP_W-1){1'b1}}};
      end else if (lin_vld) begin
        // keep msb, invert the rest for the negative slope DAC
        dac_dat_o[i] <= {lin_dat[SMP_W-1], ~lin_dat[SMP_W-2:0]};
      end
    end

  end : g_ch

endmodule : dac_back

//--- hw/adc_front.sv
`timescale 1ns/1ns

module adc_front import rp_pkg::*; #(
  parameter int CH_N = 2
) (
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // raw pin words
  input  raw_t     [CH_N-1:0]   adc_dat_i,
  // per channel loopback select
  input  logic     [CH_N-1:0]   loop_i,
  input  cal_t     [CH_N-1:0]   adc_cal_i,
  // calibrated DAC stream for loopback
  input  smp_str_t [CH_N-1:0]   dac_lin_i,
  // calibrated ADC stream, consumer takes every sample
  output smp_str_t [CH_N-1:0]   adc_o
);

  for (genvar i = 0; i < CH_N; i++) begin : g_ch

    smp_t smp_fmt;
    smp_t smp_q;
    logic vld_q;
    logic lin_vld;
    smp_t lin_dat;

    // pin word to signed, keep msb and invert the rest
    assign smp_fmt = {adc_dat_i[i][SMP_W-1], ~adc_dat_i[i][SMP_W-2:0]};

    //////////////////////////////////////////////////////////////////////////
    // sample register with loopback select
    //////////////////////////////////////////////////////////////////////////

    // pins are always valid, loopback follows DAC valid
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        vld_q <= 1'b0;
      end else begin
        vld_q <= loop_i[i] ? dac_lin_i[i].vld : 1'b1;
      end
    end

    always_ff @(posedge adc_clk) begin
      smp_q <= loop_i[i] ? dac_lin_i[i].dat : smp_fmt;
    end

    // ADC calibration, never back-pressured
    lin_scale #(
      .DT (smp_t)
    ) u_lin (
      .clk_i     (adc_clk),
      .rst_i     (top_rst),
      .cal_i     (adc_cal_i[i]),
      .in_vld_i  (vld_q),
      .in_dat_i  (smp_q),
      .in_rdy_o  (),
      .out_vld_o (lin_vld),
      .out_dat_o (lin_dat),
      .out_rdy_i (1'b1)
    );

    assign adc_o[i] = '{vld: lin_vld, dat: lin_dat};

  end : g_ch

endmodule : adc_front

//--- hw/lin_scale.sv
`timescale 1ns/1ns

module lin_scale import rp_pkg::*; #(
  parameter type DT = smp_t
) (
  input  logic clk_i,
  input  logic rst_i,
  // gain and offset
  input  cal_t cal_i,
  // input stream
  input  logic in_vld_i,
  input  DT    in_dat_i,
  output logic in_rdy_o,
  // output stream
  output logic out_vld_o,
  output DT    out_dat_o,
  input  logic out_rdy_i
);

  // payload width and full product width
  localparam int DW = $bits(DT);
  localparam int PW = DW + $bits(mul_t);

  logic signed [PW-1:0] prd;
  logic signed [PW-1:0] sum;
  logic                 ovf;
  DT                    sat;

  ////////////////////////////////////////////////////////////////////////////
  // multiply, shift, offset, saturate
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // full precision product
    prd = $signed(in_dat_i) * cal_i.mul;
    // drop gain fraction, add sign extended offset
    sum = (prd >>> MUL_FRAC) + PW'(cal_i.sum);
    // result fits only if all bits above the sample sign match
    ovf = (sum[PW-1:DW-1] != {(PW-DW+1){sum[PW-1]}});
    if (ovf) begin
      // clamp to most negative or most positive
      sat = sum[PW-1] ? DT'({1'b1, {(DW-1){1'b0}}}) : DT'({1'b0, {(DW-1){1'b1}}});
    end else begin
      sat = DT'(sum[DW-1:0]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register and handshake
  ////////////////////////////////////////////////////////////////////////////

  // room when empty or when downstream takes the current item
  assign in_rdy_o = ~out_vld_o | out_rdy_i;

  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      out_vld_o <= 1'b0;
    end else if (in_rdy_o) begin
      out_vld_o <= in_vld_i;
    end
  end

  // payload loads on input transfer only
  always_ff @(posedge clk_i) begin
    if (in_vld_i && in_rdy_o) begin
      out_dat_o <= sat;
    end
  end

endmodule : lin_scale

//--- hw/rp_pkg.sv
package rp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and fixed point format
  ////////////////////////////////////////////////////////////////////////////

  // ADC and DAC sample width
  localparam int SMP_W = 14;

  // gain fraction bits, unity gain is 2**13
  localparam int MUL_FRAC = 13;

  ////////////////////////////////////////////////////////////////////////////
  // sample and code types
  ////////////////////////////////////////////////////////////////////////////

  // signed sample, same for ADC and DAC side
  typedef logic signed [SMP_W-1:0] smp_t;

  // unsigned pin word or DAC code
  typedef logic [14-1:0] raw_t;

  // calibration gain and offset
  typedef logic signed [16-1:0] mul_t;
  typedef logic signed [14-1:0] sum_t;

  // one channel's calibration
  typedef struct packed {
    mul_t mul;
    sum_t sum;
  } cal_t;

  ////////////////////////////////////////////////////////////////////////////
  // forward stream, ready travels separately
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic vld;
    smp_t dat;
  } smp_str_t;

endpackage : rp_pkg
